//--- mem_align_pkg.sv
`default_nettype none

package mem_align_pkg;

    localparam int LINE_BYTES       = 16;
    localparam int LINE_OFFSET_BITS = 4;
    localparam int TLB_ENTRIES      = 8;
    localparam int PAGE_OFFSET_BITS = 12;

    localparam logic [1:0] FAULT_NONE = 2'd0;
    localparam logic [1:0] FAULT_MISS = 2'd1;
    localparam logic [1:0] FAULT_PROT = 2'd2;

    typedef logic [31:0]  vaddr_t;
    typedef logic [31:0]  paddr_t;
    typedef logic [19:0]  vpn_t;
    typedef logic [19:0]  pfn_t;
    typedef logic [3:0]   line_offset_t;
    typedef logic [15:0]  byte_mask_t;
    typedef logic [127:0] line_data_t;
    typedef logic [63:0]  store_data_t;
    // 0..3 select 1, 2, 4 or 8 bytes
    typedef logic [1:0]   size_code_t;
    typedef logic [2:0]   tlb_index_t;

    typedef struct packed {
        logic        valid;
        vaddr_t      vaddr;
        size_code_t  size;
        logic        read;
        logic        write;
        logic        from_bus;
        store_data_t data;
    } mem_req_t;

    typedef struct packed {
        logic valid;
        logic writable;
        logic uncached;
        vpn_t vpn;
        pfn_t pfn;
    } tlb_entry_t;

    typedef struct packed {
        logic hit;
        logic writable;
        logic uncached;
        pfn_t pfn;
    } tlb_result_t;

    typedef struct packed {
        paddr_t     line_addr;
        byte_mask_t mask;
        line_data_t data;
        logic       write;
        logic       uncached;
        logic       from_bus;
    } cache_part_t;

    typedef struct packed {
        vaddr_t     part0_addr;
        vaddr_t     part1_addr;
        byte_mask_t mask0;
        byte_mask_t mask1;
        line_data_t data0;
        line_data_t data1;
        logic       need_part1;
    } split_t;

    typedef enum logic [1:0] {
        IDLE,
        PART0,
        PART1
    } seq_state_t;

endpackage

`default_nettype wire

//--- fill_pointer.sv
`timescale 1ns/1ps
`default_nettype none

module fill_pointer (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire [mem_align_pkg::TLB_ENTRIES-1:0]    occupied,
    input  wire                                     advance,
    output mem_align_pkg::tlb_index_t               slot
);

    mem_align_pkg::tlb_index_t rr_q;
    mem_align_pkg::tlb_index_t free_slot;
    logic                      any_free;

    assign any_free = ~&occupied;

    // Lowest free slot, scanned from the top so slot 0 wins
    always_comb begin
        free_slot = '0;
        for (int i = mem_align_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (!occupied[i]) begin
                free_slot = mem_align_pkg::tlb_index_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rr_q <= '0;
        end else if (advance && !any_free) begin
            rr_q <= rr_q + 3'd1;
        end
    end

    assign slot = any_free ? free_slot : rr_q;

endmodule

`default_nettype wire

//--- tlb_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire mem_align_pkg::vpn_t                vpn0,
    input  wire mem_align_pkg::vpn_t                vpn1,
    input  wire                                     fill_valid,
    input  wire mem_align_pkg::tlb_entry_t          fill_entry,
    input  wire                                     flush,
    output mem_align_pkg::tlb_result_t              result0,
    output mem_align_pkg::tlb_result_t              result1,
    output logic [mem_align_pkg::TLB_ENTRIES-1:0]   occupied
);

    mem_align_pkg::tlb_entry_t          entries [mem_align_pkg::TLB_ENTRIES];
    logic [mem_align_pkg::TLB_ENTRIES-1:0] valid_q;
    mem_align_pkg::tlb_index_t          fill_slot;

    fill_pointer u_fill_pointer (
        .clk      (clk),
        .reset    (reset),
        .occupied (valid_q),
        .advance  (fill_valid),
        .slot     (fill_slot)
    );

    // Parallel compare against every valid entry
    function automatic mem_align_pkg::tlb_result_t lookup(input mem_align_pkg::vpn_t vpn);
        mem_align_pkg::tlb_result_t res;
        res = '0;
        for (int i = 0; i < mem_align_pkg::TLB_ENTRIES; i++) begin
            if (valid_q[i] && entries[i].vpn == vpn) begin
                res.hit      = 1'b1;
                res.writable = entries[i].writable;
                res.uncached = entries[i].uncached;
                res.pfn      = entries[i].pfn;
            end
        end
        return res;
    endfunction

    always_comb begin
        result0 = lookup(vpn0);
        result1 = lookup(vpn1);
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[fill_slot] <= fill_entry.valid;
        end
    end

    // Tag and frame storage
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            entries[fill_slot] <= fill_entry;
        end
    end

    assign occupied = valid_q;

endmodule

`default_nettype wire

//--- access_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module access_splitter (
    input  wire mem_align_pkg::mem_req_t req,
    output mem_align_pkg::split_t        split
);

    mem_align_pkg::line_offset_t      offset;
    logic [3:0]                       bytes;
    logic [4:0]                       end_pos;
    mem_align_pkg::byte_mask_t [1:0]  span_mask;
    mem_align_pkg::line_data_t [1:0]  lanes;
    logic [31-mem_align_pkg::LINE_OFFSET_BITS:0] next_line;

    assign offset = req.vaddr[mem_align_pkg::LINE_OFFSET_BITS-1:0];

    // Size code to byte count
    always_comb begin
        case (req.size)
            2'd0:    bytes = 4'd1;
            2'd1:    bytes = 4'd2;
            2'd2:    bytes = 4'd4;
            default: bytes = 4'd8;
        endcase
    end

    // One past the last byte, may run into the next line
    assign end_pos = {1'b0, offset} + {1'b0, bytes};

    // Byte enables over this line and the following one
    always_comb begin
        for (int i = 0; i < 2 * mem_align_pkg::LINE_BYTES; i++) begin
            span_mask[i / mem_align_pkg::LINE_BYTES][i % mem_align_pkg::LINE_BYTES] =
                (i >= int'(offset)) && (i < int'(end_pos));
        end
    end

    // Byte barrel shift, one stage per offset bit
    always_comb begin
        lanes[1] = '0;
        lanes[0] = mem_align_pkg::line_data_t'(req.data);
        for (int k = 0; k < mem_align_pkg::LINE_OFFSET_BITS; k++) begin
            if (offset[k]) begin
                lanes = lanes << (8 * (1 << k));
            end
        end
    end

    assign next_line = req.vaddr[31:mem_align_pkg::LINE_OFFSET_BITS] + 1'b1;

    always_comb begin
        split.part0_addr = {req.vaddr[31:mem_align_pkg::LINE_OFFSET_BITS],
                            mem_align_pkg::line_offset_t'(0)};
        split.part1_addr = {next_line, mem_align_pkg::line_offset_t'(0)};
        split.mask0      = span_mask[0];
        split.mask1      = span_mask[1];
        // Upper half holds the bytes that spill past the line end
        split.data0      = lanes[0];
        split.data1      = lanes[1];
        split.need_part1 = int'(end_pos) > mem_align_pkg::LINE_BYTES;
    end

endmodule

`default_nettype wire

//--- access_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module access_sequencer (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire mem_align_pkg::mem_req_t        req,
    input  wire mem_align_pkg::split_t          split,
    input  wire mem_align_pkg::tlb_result_t     result0,
    input  wire mem_align_pkg::tlb_result_t     result1,
    output mem_align_pkg::mem_req_t             held_req,
    output logic                                busy,
    output logic                                cache_valid,
    output mem_align_pkg::cache_part_t          cache_part,
    output logic                                done,
    output logic                                fault,
    output logic [1:0]                          fault_code
);

    mem_align_pkg::seq_state_t state_q;
    mem_align_pkg::seq_state_t state_d;
    logic                      miss;
    logic                      prot;
    logic                      bad;
    logic                      in_part0;
    logic                      in_part1;

    // Frame number plus in-page line bits
    function automatic mem_align_pkg::paddr_t phys_line(input mem_align_pkg::pfn_t pfn,
                                                        input mem_align_pkg::vaddr_t va);
        return {pfn, va[mem_align_pkg::PAGE_OFFSET_BITS-1:mem_align_pkg::LINE_OFFSET_BITS],
                mem_align_pkg::line_offset_t'(0)};
    endfunction

    assign in_part0 = state_q == mem_align_pkg::PART0;
    assign in_part1 = state_q == mem_align_pkg::PART1;

    // Both halves are checked before anything goes out
    assign miss = !result0.hit || (split.need_part1 && !result1.hit);
    assign prot = held_req.write &&
                  ((result0.hit && !result0.writable) ||
                   (split.need_part1 && result1.hit && !result1.writable));
    assign bad  = miss || prot;

    assign busy        = state_q != mem_align_pkg::IDLE;
    assign fault       = in_part0 && bad;
    assign fault_code  = !fault ? mem_align_pkg::FAULT_NONE :
                         miss   ? mem_align_pkg::FAULT_MISS : mem_align_pkg::FAULT_PROT;
    assign cache_valid = (in_part0 && !bad) || in_part1;
    assign done        = (in_part0 && !bad && !split.need_part1) || in_part1;

    always_comb begin
        cache_part.write    = held_req.write;
        cache_part.from_bus = held_req.from_bus;
        if (in_part1) begin
            cache_part.line_addr = phys_line(result1.pfn, split.part1_addr);
            cache_part.mask      = split.mask1;
            cache_part.data      = split.data1;
            cache_part.uncached  = result1.uncached;
        end else begin
            cache_part.line_addr = phys_line(result0.pfn, split.part0_addr);
            cache_part.mask      = split.mask0;
            cache_part.data      = split.data0;
            cache_part.uncached  = result0.uncached;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_align_pkg::IDLE:  if (req.valid) state_d = mem_align_pkg::PART0;
            mem_align_pkg::PART0: state_d = (!bad && split.need_part1) ? mem_align_pkg::PART1
                                                                        : mem_align_pkg::IDLE;
            default:              state_d = mem_align_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= mem_align_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Requests only land while idle
    always_ff @(posedge clk) begin
        if (!busy && req.valid) begin
            held_req <= req;
        end
    end

endmodule

`default_nettype wire

//--- mem_align_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_align_top (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire mem_align_pkg::mem_req_t        req,
    output wire                                 busy,
    input  wire                                 fill_valid,
    input  wire mem_align_pkg::tlb_entry_t      fill_entry,
    input  wire                                 flush,
    output wire                                 cache_valid,
    output wire mem_align_pkg::cache_part_t     cache_part,
    output wire                                 done,
    output wire                                 fault,
    output wire [1:0]                           fault_code
);

    wire mem_align_pkg::mem_req_t    held_req;
    wire mem_align_pkg::split_t      split;
    wire mem_align_pkg::tlb_result_t result0;
    wire mem_align_pkg::tlb_result_t result1;

    access_sequencer u_access_sequencer (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .split       (split),
        .result0     (result0),
        .result1     (result1),
        .held_req    (held_req),
        .busy        (busy),
        .cache_valid (cache_valid),
        .cache_part  (cache_part),
        .done        (done),
        .fault       (fault),
        .fault_code  (fault_code)
    );

    access_splitter u_access_splitter (
        .req   (held_req),
        .split (split)
    );

    // Each part translated on its own page
    tlb_lookup u_tlb_lookup (
        .clk        (clk),
        .reset      (reset),
        .vpn0       (split.part0_addr[31:mem_align_pkg::PAGE_OFFSET_BITS]),
        .vpn1       (split.part1_addr[31:mem_align_pkg::PAGE_OFFSET_BITS]),
        .fill_valid (fill_valid),
        .fill_entry (fill_entry),
        .flush      (flush),
        .result0    (result0),
        .result1    (result1),
        .occupied   ()
    );

endmodule

`default_nettype wire

//--- mem_align_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mem_align_properties (
    input wire                            clk,
    input wire                            reset,
    input wire mem_align_pkg::seq_state_t state,
    input wire                            busy,
    input wire                            cache_valid,
    input wire                            done,
    input wire                            fault
);

    // No cache traffic from an idle sequencer
    idle_quiet: assert property (@(posedge clk) disable iff (reset)
        (state == mem_align_pkg::IDLE) |-> !cache_valid)
        else $error("cache_valid raised while the sequencer is idle");

    fault_excludes_part: assert property (@(posedge clk) disable iff (reset)
        !(fault && cache_valid))
        else $error("fault and cache_valid pulsed in the same cycle");

    // done marks the last part going out
    done_with_part: assert property (@(posedge clk) disable iff (reset)
        done |-> cache_valid)
        else $error("done pulsed without cache_valid");

    busy_release: assert property (@(posedge clk) disable iff (reset)
        $fell(busy) |-> $past(done || fault))
        else $error("busy dropped without a done or fault in the cycle before");

endmodule

`default_nettype wire

//--- tb_mem_align.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_align;

    localparam int NUM_VECTORS = 7;
    localparam int TIMEOUT     = 20;

    typedef struct packed {
        mem_align_pkg::vaddr_t      vaddr;
        mem_align_pkg::size_code_t  size;
        logic                       write;
        logic                       from_bus;
        mem_align_pkg::store_data_t data;
        logic                       poke;
        logic [1:0]                 exp_code;
        logic [1:0]                 exp_parts;
        logic                       exp_uncached;
        mem_align_pkg::paddr_t      exp_addr0;
        mem_align_pkg::paddr_t      exp_addr1;
        mem_align_pkg::byte_mask_t  exp_mask0;
        mem_align_pkg::byte_mask_t  exp_mask1;
        mem_align_pkg::line_data_t  exp_data0;
        mem_align_pkg::line_data_t  exp_data1;
    } vector_t;

    logic                            clk;
    logic                            reset;
    mem_align_pkg::mem_req_t         req;
    logic                            fill_valid;
    mem_align_pkg::tlb_entry_t       fill_entry;
    logic                            flush;
    wire                             busy;
    wire                             cache_valid;
    wire mem_align_pkg::cache_part_t cache_part;
    wire                             done;
    wire                             fault;
    wire [1:0]                       fault_code;

    vector_t                         vectors [NUM_VECTORS];
    string                           vector_names [NUM_VECTORS];

    int                              errors;
    int                              checks;
    int                              got_parts;
    int                              got_stray;
    int                              got_end_cycle;
    logic [1:0]                      got_code;
    mem_align_pkg::cache_part_t      got_part [2];
    int                              got_cycle [2];

    mem_align_top u_mem_align_top (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .busy        (busy),
        .fill_valid  (fill_valid),
        .fill_entry  (fill_entry),
        .flush       (flush),
        .cache_valid (cache_valid),
        .cache_part  (cache_part),
        .done        (done),
        .fault       (fault),
        .fault_code  (fault_code)
    );

    bind access_sequencer mem_align_properties u_seq_properties (
        .clk         (clk),
        .reset       (reset),
        .state       (state_q),
        .busy        (busy),
        .cache_valid (cache_valid),
        .done        (done),
        .fault       (fault)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input string what,
                         input logic [127:0] expected, input logic [127:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s %s: expected %0h, actual %0h", name, what, expected, actual);
        end
    endtask

    task automatic fill_tlb(input mem_align_pkg::vpn_t vpn, input mem_align_pkg::pfn_t pfn,
                            input logic writable, input logic uncached);
        @(negedge clk);
        fill_valid = 1'b1;
        fill_entry = '{valid: 1'b1, writable: writable, uncached: uncached, vpn: vpn, pfn: pfn};
        @(negedge clk);
        fill_valid = 1'b0;
    endtask

    task automatic flush_tlb();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic run_request(input mem_align_pkg::vaddr_t vaddr,
                               input mem_align_pkg::size_code_t size, input logic write,
                               input logic from_bus, input mem_align_pkg::store_data_t data,
                               input logic poke);
        int   cyc;
        logic finished;
        got_parts     = 0;
        got_stray     = 0;
        got_end_cycle = 0;
        got_code      = 2'd0;
        got_part[0]   = '0;
        got_part[1]   = '0;
        got_cycle[0]  = 0;
        got_cycle[1]  = 0;
        cyc           = 0;
        finished      = 1'b0;
        @(negedge clk);
        req = '{valid: 1'b1, vaddr: vaddr, size: size, read: !write, write: write,
                from_bus: from_bus, data: data};
        while (!finished && cyc < TIMEOUT) begin
            @(negedge clk);
            cyc++;
            if (cyc == 1) begin
                // A wrongly taken strobe would fault on this unmapped page
                req.valid = poke;
                req.vaddr = 32'h0003_0000;
            end
            if (cache_valid) begin
                if (got_parts < 2) begin
                    got_part[got_parts]  = cache_part;
                    got_cycle[got_parts] = cyc;
                end
                got_parts++;
            end
            if (fault) begin
                got_code = fault_code;
            end
            if (done || fault) begin
                finished      = 1'b1;
                got_end_cycle = cyc;
            end
        end
        req.valid = 1'b0;
        if (!finished) begin
            errors++;
            $display("Timeout: no done or fault within %0d cycles for address %h",
                     TIMEOUT, vaddr);
        end
        repeat (3) begin
            @(negedge clk);
            if (cache_valid || busy || fault) begin
                got_stray++;
            end
        end
    endtask

    task automatic check_vector(input int idx);
        vector_t v;
        string   name;
        int      expected_end;
        v            = vectors[idx];
        name         = vector_names[idx];
        expected_end = (v.exp_parts == 2'd0) ? 1 : int'(v.exp_parts);
        run_request(v.vaddr, v.size, v.write, v.from_bus, v.data, v.poke);
        check(name, "fault code", 128'(v.exp_code), 128'(got_code));
        check(name, "part count", 128'(v.exp_parts), 128'(got_parts));
        check(name, "stray activity", 128'(0), 128'(got_stray));
        check(name, "end cycle", 128'(expected_end), 128'(got_end_cycle));
        if (v.exp_parts >= 2'd1) begin
            check(name, "part0 cycle", 128'(1), 128'(got_cycle[0]));
            check(name, "part0 address", 128'(v.exp_addr0), 128'(got_part[0].line_addr));
            check(name, "part0 mask", 128'(v.exp_mask0), 128'(got_part[0].mask));
            check(name, "part0 data", v.exp_data0, got_part[0].data);
            check(name, "part0 uncached", 128'(v.exp_uncached), 128'(got_part[0].uncached));
            check(name, "part0 write", 128'(v.write), 128'(got_part[0].write));
            check(name, "part0 from_bus", 128'(v.from_bus), 128'(got_part[0].from_bus));
        end
        if (v.exp_parts == 2'd2) begin
            check(name, "part1 cycle", 128'(2), 128'(got_cycle[1]));
            check(name, "part1 address", 128'(v.exp_addr1), 128'(got_part[1].line_addr));
            check(name, "part1 mask", 128'(v.exp_mask1), 128'(got_part[1].mask));
            check(name, "part1 data", v.exp_data1, got_part[1].data);
            check(name, "part1 uncached", 128'(v.exp_uncached), 128'(got_part[1].uncached));
            check(name, "part1 write", 128'(v.write), 128'(got_part[1].write));
            check(name, "part1 from_bus", 128'(v.from_bus), 128'(got_part[1].from_bus));
        end
    endtask

    task automatic expect_lookup(input string name, input mem_align_pkg::vpn_t vpn,
                                 input logic hit, input mem_align_pkg::pfn_t pfn);
        run_request({vpn, 12'h004}, 2'd0, 1'b0, 1'b0, 64'h0, 1'b0);
        if (hit) begin
            check(name, "fault code", 128'(0), 128'(got_code));
            check(name, "part count", 128'(1), 128'(got_parts));
            check(name, "part0 address", 128'({pfn, 12'h000}), 128'(got_part[0].line_addr));
        end else begin
            check(name, "fault code", 128'(1), 128'(got_code));
            check(name, "part count", 128'(0), 128'(got_parts));
        end
        check(name, "stray activity", 128'(0), 128'(got_stray));
    endtask

    // Pages 0x10, 0x11 and 0x40 writable, 0x20 read-only and uncached, 0x41 unmapped
    task automatic load_vectors();
        vector_names[0] = "rd4_aligned";
        vectors[0] = '{vaddr: 32'h0001_0128, size: 2'd2, write: 1'b0, from_bus: 1'b0,
            data: 64'h0000_0000_1122_3344, poke: 1'b0, exp_code: 2'd0, exp_parts: 2'd1,
            exp_uncached: 1'b0, exp_addr0: 32'h8001_0120, exp_addr1: 32'h0,
            exp_mask0: 16'h0F00, exp_mask1: 16'h0000,
            exp_data0: 128'h0000_0000_1122_3344_0000_0000_0000_0000, exp_data1: 128'h0};
        vector_names[1] = "wr8_cross";
        vectors[1] = '{vaddr: 32'h0001_034C, size: 2'd3, write: 1'b1, from_bus: 1'b1,
            data: 64'h8877_6655_4433_2211, poke: 1'b0, exp_code: 2'd0, exp_parts: 2'd2,
            exp_uncached: 1'b0, exp_addr0: 32'h8001_0340, exp_addr1: 32'h8001_0350,
            exp_mask0: 16'hF000, exp_mask1: 16'h000F,
            exp_data0: 128'h4433_2211_0000_0000_0000_0000_0000_0000,
            exp_data1: 128'h0000_0000_0000_0000_0000_0000_8877_6655};
        vector_names[2] = "rd_two_pages";
        vectors[2] = '{vaddr: 32'h0001_0FFE, size: 2'd2, write: 1'b0, from_bus: 1'b0,
            data: 64'h0000_0000_DDCC_BBAA, poke: 1'b0, exp_code: 2'd0, exp_parts: 2'd2,
            exp_uncached: 1'b0, exp_addr0: 32'h8001_0FF0, exp_addr1: 32'h9002_2000,
            exp_mask0: 16'hC000, exp_mask1: 16'h0003,
            exp_data0: 128'hBBAA_0000_0000_0000_0000_0000_0000_0000,
            exp_data1: 128'h0000_0000_0000_0000_0000_0000_0000_DDCC};
        vector_names[3] = "cross_unmapped";
        vectors[3] = '{vaddr: 32'h0004_0FFC, size: 2'd3, write: 1'b0, from_bus: 1'b0,
            data: 64'h0, poke: 1'b0, exp_code: 2'd1, exp_parts: 2'd0, exp_uncached: 1'b0,
            exp_addr0: 32'h0, exp_addr1: 32'h0, exp_mask0: 16'h0, exp_mask1: 16'h0,
            exp_data0: 128'h0, exp_data1: 128'h0};
        vector_names[4] = "wr_protected";
        vectors[4] = '{vaddr: 32'h0002_0010, size: 2'd2, write: 1'b1, from_bus: 1'b0,
            data: 64'h0123_4567, poke: 1'b0, exp_code: 2'd2, exp_parts: 2'd0,
            exp_uncached: 1'b0,
            exp_addr0: 32'h0, exp_addr1: 32'h0, exp_mask0: 16'h0, exp_mask1: 16'h0,
            exp_data0: 128'h0, exp_data1: 128'h0};
        vector_names[5] = "rd_uncached";
        vectors[5] = '{vaddr: 32'h0002_0010, size: 2'd2, write: 1'b0, from_bus: 1'b1,
            data: 64'h0, poke: 1'b0, exp_code: 2'd0, exp_parts: 2'd1, exp_uncached: 1'b1,
            exp_addr0: 32'hA002_0010, exp_addr1: 32'h0, exp_mask0: 16'h000F,
            exp_mask1: 16'h0, exp_data0: 128'h0, exp_data1: 128'h0};
        vector_names[6] = "busy_ignored";
        vectors[6] = '{vaddr: 32'h0001_05AE, size: 2'd2, write: 1'b1, from_bus: 1'b0,
            data: 64'h0000_0000_DDCC_BBAA, poke: 1'b1, exp_code: 2'd0, exp_parts: 2'd2,
            exp_uncached: 1'b0, exp_addr0: 32'h8001_05A0, exp_addr1: 32'h8001_05B0,
            exp_mask0: 16'hC000, exp_mask1: 16'h0003,
            exp_data0: 128'hBBAA_0000_0000_0000_0000_0000_0000_0000,
            exp_data1: 128'h0000_0000_0000_0000_0000_0000_0000_DDCC};
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        reset      = 1'b1;
        req        = '0;
        fill_valid = 1'b0;
        fill_entry = '0;
        flush      = 1'b0;
        load_vectors();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check("after_reset", "busy", 128'(0), 128'(busy));
        check("after_reset", "cache_valid", 128'(0), 128'(cache_valid));
        check("after_reset", "done", 128'(0), 128'(done));
        check("after_reset", "fault", 128'(0), 128'(fault));

        fill_tlb(20'h00010, 20'h80010, 1'b1, 1'b0);
        fill_tlb(20'h00011, 20'h90022, 1'b1, 1'b0);
        fill_tlb(20'h00020, 20'hA0020, 1'b0, 1'b1);
        fill_tlb(20'h00040, 20'hB0040, 1'b1, 1'b0);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            check_vector(i);
        end

        // Eight fills take every slot and the ninth replaces slot 0
        flush_tlb();
        for (int i = 0; i < 9; i++) begin
            fill_tlb(20'h00100 + 20'(i), 20'hC0000 + 20'(i), 1'b1, 1'b0);
        end
        expect_lookup("evicted_first", 20'h00100, 1'b0, 20'h0);
        expect_lookup("kept_second", 20'h00101, 1'b1, 20'hC0001);
        expect_lookup("ninth_fill", 20'h00108, 1'b1, 20'hC0008);
        flush_tlb();
        for (int i = 0; i < 9; i++) begin
            expect_lookup($sformatf("flushed_%0d", i), 20'h00100 + 20'(i), 1'b0, 20'h0);
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
mem_align_pkg.sv
fill_pointer.sv
tlb_lookup.sv
access_splitter.sv
access_sequencer.sv
mem_align_top.sv
mem_align_properties.sv
tb_mem_align.sv

//--- Makefile
SIM  := obj_dir/Vtb_mem_align
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: run

$(SIM): files.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_mem_align -f files.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
